//--- logic/aesMathPkg.sv
`default_nettype none

package aesMathPkg;

    typedef logic [7:0] aesByte;

    // Forward S-box, indexed by the input byte
    localparam aesByte sBox [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // Rounds 1 to 10, entry 0 is round 1
    localparam aesByte rconTable [10] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // Multiply by x in GF(2^8), reduced by x^8 + x^4 + x^3 + x + 1
    function automatic aesByte xtime(input aesByte value);
        return {value[6:0], 1'b0} ^ (value[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

`default_nettype wire

//--- logic/aesUnitPkg.sv
`default_nettype none

package aesUnitPkg;

    typedef logic [31:0] aesWord;
    typedef logic [1:0]  rowIndex;  // Row or byte rotation count
    typedef logic [3:0]  roundNum;

    // Codes 6 and 7 are left undefined and give a zero result
    typedef enum logic [2:0] {
        opXor       = 3'd0,
        opSubWord   = 3'd1,
        opShiftRow  = 3'd2,
        opMixColumn = 3'd3,
        opRcon      = 3'd4,
        opPass      = 3'd5
    } aesOp;

    typedef enum logic [1:0] {
        regSrcA   = 2'd0,
        regSrcB   = 2'd1,
        regCtrl   = 2'd2,
        regResult = 2'd3
    } regAddr;

    // Low bit of each field in the control word
    localparam int ctrlOpLsb    = 0;
    localparam int ctrlRowLsb   = 4;
    localparam int ctrlRoundLsb = 8;

endpackage

`default_nettype wire

//--- logic/wbCmdPort.sv
`timescale 1ns/1ps
`default_nettype none

module wbCmdPort (
    input  logic                clk,
    input  logic                arstN,
    input  logic                wbCyc,
    input  logic                wbStb,
    input  logic                wbWe,
    input  aesUnitPkg::regAddr  wbAdr,
    input  aesUnitPkg::aesWord  wbDatIn,
    output aesUnitPkg::aesWord  wbDatOut,
    output logic                wbAck,
    input  aesUnitPkg::aesWord  result,
    output logic                issue,
    output aesUnitPkg::aesWord  opA,
    output aesUnitPkg::aesWord  opB,
    output aesUnitPkg::aesOp    op,
    output aesUnitPkg::rowIndex row,
    output aesUnitPkg::roundNum round
);

    logic                request;     // New transfer, not yet acknowledged
    logic                accept;
    logic                ctrlWrite;
    logic [1:0]          inFlight;    // Bit 0 in lane stage, bit 1 in combiner stage
    aesUnitPkg::aesOp    newOp;
    aesUnitPkg::rowIndex newRow;
    aesUnitPkg::roundNum newRound;
    aesUnitPkg::aesWord  ctrlWord;
    aesUnitPkg::aesWord  readData;

    assign request   = wbCyc && wbStb && !wbAck;
    // Result reads wait until the pipeline has drained
    assign accept    = request && (wbWe || wbAdr != aesUnitPkg::regResult || inFlight == 2'b00);
    assign ctrlWrite = accept && wbWe && wbAdr == aesUnitPkg::regCtrl;
    assign issue     = inFlight[0];  // High in the acknowledge cycle of the control write

    always_comb begin
        newOp    = aesUnitPkg::aesOp'(wbDatIn[aesUnitPkg::ctrlOpLsb +: 3]);
        newRow   = wbDatIn[aesUnitPkg::ctrlRowLsb +: 2];
        newRound = wbDatIn[aesUnitPkg::ctrlRoundLsb +: 4];
    end

    always_comb begin
        ctrlWord = '0;
        ctrlWord[aesUnitPkg::ctrlOpLsb +: 3]    = op;
        ctrlWord[aesUnitPkg::ctrlRowLsb +: 2]   = row;
        ctrlWord[aesUnitPkg::ctrlRoundLsb +: 4] = round;
    end

    always_comb begin
        case (wbAdr)
            aesUnitPkg::regSrcA: readData = opA;
            aesUnitPkg::regSrcB: readData = opB;
            aesUnitPkg::regCtrl: readData = ctrlWord;
            default:             readData = result;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbAck    <= 1'b0;
            inFlight <= 2'b00;
            wbDatOut <= '0;
            opA      <= '0;
            opB      <= '0;
            op       <= aesUnitPkg::opXor;
            row      <= '0;
            round    <= '0;
        end else begin
            wbAck    <= accept;
            inFlight <= {inFlight[0], ctrlWrite};
            if (accept && wbWe) begin
                case (wbAdr)
                    aesUnitPkg::regSrcA: opA <= wbDatIn;
                    aesUnitPkg::regSrcB: opB <= wbDatIn;
                    aesUnitPkg::regCtrl: begin
                        op    <= newOp;
                        row   <= newRow;
                        round <= newRound;
                    end
                    default: ;  // Result register is read only
                endcase
            end
            if (accept && !wbWe) begin
                wbDatOut <= readData;
            end
        end
    end

    // Master must hold its request until the acknowledge
    ackNeedsRequest: assert property (@(posedge clk) disable iff (!arstN)
        wbAck |-> (wbCyc && wbStb));

    ackSingleCycle: assert property (@(posedge clk) disable iff (!arstN)
        wbAck |=> !wbAck);

endmodule

`default_nettype wire

//--- logic/byteLane.sv
`timescale 1ns/1ps
`default_nettype none

module byteLane (
    input  logic               clk,
    input  logic               arstN,
    input  logic               issue,
    input  aesMathPkg::aesByte dataByte,
    input  aesMathPkg::aesByte keyByte,
    output aesMathPkg::aesByte plain,
    output aesMathPkg::aesByte keyed,
    output aesMathPkg::aesByte subbed,
    output aesMathPkg::aesByte times2,
    output aesMathPkg::aesByte times3
);

    aesMathPkg::aesByte doubled;

    assign doubled = aesMathPkg::xtime(dataByte);

    // Every candidate is computed, the combiner picks
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            plain  <= '0;
            keyed  <= '0;
            subbed <= '0;
            times2 <= '0;
            times3 <= '0;
        end else if (issue) begin
            plain  <= dataByte;
            keyed  <= dataByte ^ keyByte;
            subbed <= aesMathPkg::sBox[dataByte];
            times2 <= doubled;
            times3 <= doubled ^ dataByte;  // 3x = 2x + x
        end
    end

endmodule

`default_nettype wire

//--- logic/wordCombiner.sv
`timescale 1ns/1ps
`default_nettype none

module wordCombiner (
    input  logic                clk,
    input  logic                arstN,
    input  logic                issue,
    input  aesUnitPkg::aesOp    op,
    input  aesUnitPkg::rowIndex row,
    input  aesUnitPkg::roundNum round,
    input  aesMathPkg::aesByte  plain [4],
    input  aesMathPkg::aesByte  keyed [4],
    input  aesMathPkg::aesByte  subbed [4],
    input  aesMathPkg::aesByte  times2 [4],
    input  aesMathPkg::aesByte  times3 [4],
    output aesUnitPkg::aesWord  result
);

    logic                validQ;       // Lanes hold a fresh operation
    aesUnitPkg::aesOp    opQ;
    aesUnitPkg::rowIndex rowQ;
    aesUnitPkg::roundNum roundQ;
    aesMathPkg::aesByte  rotated [4];
    aesMathPkg::aesByte  mixed [4];
    aesMathPkg::aesByte  rconByte;
    aesUnitPkg::aesWord  plainWord;
    aesUnitPkg::aesWord  nextResult;

    // Control follows the lanes by one stage
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
            opQ    <= aesUnitPkg::opXor;
            rowQ   <= '0;
            roundQ <= '0;
        end else begin
            validQ <= issue;
            if (issue) begin
                opQ    <= op;
                rowQ   <= row;
                roundQ <= round;
            end
        end
    end

    // Lane 0 carries the most significant byte
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rotated[k] = plain[2'(k) + rowQ];
            mixed[k]   = times2[k] ^ times3[2'(k + 1)] ^ plain[2'(k + 2)] ^ plain[2'(k + 3)];
        end
    end

    always_comb begin
        rconByte = 8'h00;
        if (rowQ == 2'd0 && roundQ >= 4'd1 && roundQ <= 4'd10) begin
            rconByte = aesMathPkg::rconTable[roundQ - 4'd1];
        end
    end

    assign plainWord = {plain[0], plain[1], plain[2], plain[3]};

    always_comb begin
        case (opQ)
            aesUnitPkg::opXor:       nextResult = {keyed[0], keyed[1], keyed[2], keyed[3]};
            aesUnitPkg::opSubWord:   nextResult = {subbed[0], subbed[1], subbed[2], subbed[3]};
            aesUnitPkg::opShiftRow:  nextResult = {rotated[0], rotated[1], rotated[2], rotated[3]};
            aesUnitPkg::opMixColumn: nextResult = {mixed[0], mixed[1], mixed[2], mixed[3]};
            aesUnitPkg::opRcon:      nextResult = {plainWord[31:8], plainWord[7:0] ^ rconByte};
            aesUnitPkg::opPass:      nextResult = plainWord;
            default:                 nextResult = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result <= '0;
        end else if (validQ) begin
            result <= nextResult;
        end
    end

    // Opcode from the command port must be settled when the lanes deliver
    opcodeKnown: assert property (@(posedge clk) disable iff (!arstN)
        validQ |-> !$isunknown(opQ));

endmodule

`default_nettype wire

//--- logic/aesWordUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aesWordUnit (
    input  logic               clk,
    input  logic               arstN,
    input  logic               wbCyc,
    input  logic               wbStb,
    input  logic               wbWe,
    input  aesUnitPkg::regAddr wbAdr,
    input  aesUnitPkg::aesWord wbDatIn,
    output aesUnitPkg::aesWord wbDatOut,
    output logic               wbAck
);

    logic                issue;
    aesUnitPkg::aesWord  opA;
    aesUnitPkg::aesWord  opB;
    aesUnitPkg::aesWord  result;
    aesUnitPkg::aesOp    op;
    aesUnitPkg::rowIndex row;
    aesUnitPkg::roundNum round;
    aesMathPkg::aesByte  lanePlain [4];
    aesMathPkg::aesByte  laneKeyed [4];
    aesMathPkg::aesByte  laneSubbed [4];
    aesMathPkg::aesByte  laneTimes2 [4];
    aesMathPkg::aesByte  laneTimes3 [4];

    wbCmdPort u_cmdPort (
        .clk      (clk),
        .arstN    (arstN),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatIn  (wbDatIn),
        .wbDatOut (wbDatOut),
        .wbAck    (wbAck),
        .result   (result),
        .issue    (issue),
        .opA      (opA),
        .opB      (opB),
        .op       (op),
        .row      (row),
        .round    (round)
    );

    // Lane i works on byte i, counted from the most significant end
    for (genvar i = 0; i < 4; i++) begin : genLane
        byteLane u_lane (
            .clk      (clk),
            .arstN    (arstN),
            .issue    (issue),
            .dataByte (opA[31 - 8 * i -: 8]),
            .keyByte  (opB[31 - 8 * i -: 8]),
            .plain    (lanePlain[i]),
            .keyed    (laneKeyed[i]),
            .subbed   (laneSubbed[i]),
            .times2   (laneTimes2[i]),
            .times3   (laneTimes3[i])
        );
    end

    wordCombiner u_combiner (
        .clk    (clk),
        .arstN  (arstN),
        .issue  (issue),
        .op     (op),
        .row    (row),
        .round  (round),
        .plain  (lanePlain),
        .keyed  (laneKeyed),
        .subbed (laneSubbed),
        .times2 (laneTimes2),
        .times3 (laneTimes3),
        .result (result)
    );

endmodule

`default_nettype wire

//--- testbench/aesRefModel.svh
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// Shift-and-add product in GF(2^8)
function automatic logic [7:0] gfMultiply(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] shifted;
    acc = 8'h00;
    shifted = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) acc = acc ^ shifted;
        shifted = {shifted[6:0], 1'b0} ^ (shifted[7] ? 8'h1b : 8'h00);
    end
    return acc;
endfunction

// a^254 is the field inverse, zero maps to zero
function automatic logic [7:0] fieldInverse(input logic [7:0] a);
    logic [7:0] power;
    logic [7:0] base;
    power = 8'h01;
    base = a;
    for (int i = 0; i < 8; i++) begin
        if (i != 0) power = gfMultiply(power, base);  // Bits 1 to 7 of 254
        base = gfMultiply(base, base);
    end
    return power;
endfunction

// Field inverse followed by the affine map
function automatic logic [7:0] sboxOf(input logic [7:0] x);
    logic [7:0] inv;
    inv = fieldInverse(x);
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
        ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

function automatic logic [31:0] substituteWord(input logic [31:0] w);
    return {sboxOf(w[31:24]), sboxOf(w[23:16]), sboxOf(w[15:8]), sboxOf(w[7:0])};
endfunction

function automatic logic [31:0] rotateWord(input logic [31:0] w, input logic [1:0] n);
    case (n)
        2'd0: return w;
        2'd1: return {w[23:0], w[31:24]};
        2'd2: return {w[15:0], w[31:16]};
        default: return {w[7:0], w[31:8]};
    endcase
endfunction

function automatic logic [31:0] doubleWord(input logic [31:0] w);
    return {gfMultiply(w[31:24], 8'h02), gfMultiply(w[23:16], 8'h02),
            gfMultiply(w[15:8], 8'h02), gfMultiply(w[7:0], 8'h02)};
endfunction

// 2a0 + 3a1 + a2 + a3, with 3a1 split as 2a1 + a1
function automatic logic [31:0] mixWord(input logic [31:0] w);
    return doubleWord(w) ^ doubleWord(rotateWord(w, 2'd1)) ^ rotateWord(w, 2'd1)
        ^ rotateWord(w, 2'd2) ^ rotateWord(w, 2'd3);
endfunction

function automatic logic [7:0] roundConstant(input logic [3:0] round);
    logic [7:0] c;
    if (round < 4'd1 || round > 4'd10) return 8'h00;
    c = 8'h01;
    for (int i = 1; i < int'(round); i++) c = gfMultiply(c, 8'h02);
    return c;
endfunction

function automatic logic [31:0] expectedResult(input logic [2:0] op, input logic [31:0] a,
                                               input logic [31:0] b, input logic [1:0] row,
                                               input logic [3:0] round);
    case (op)
        aesUnitPkg::opXor:       return a ^ b;
        aesUnitPkg::opSubWord:   return substituteWord(a);
        aesUnitPkg::opShiftRow:  return rotateWord(a, row);
        aesUnitPkg::opMixColumn: return mixWord(a);
        aesUnitPkg::opRcon:      return (row == 2'd0) ? a ^ {24'h0, roundConstant(round)} : a;
        aesUnitPkg::opPass:      return a;
        default:                 return 32'h0;
    endcase
endfunction

`endif

//--- testbench/tbAesWordUnit.sv
`timescale 1ns/1ps
`default_nettype none

module tbAesWordUnit;

    localparam int ackTimeout   = 20;  // Cycles
    localparam int randomChecks = 40;

    typedef struct packed {
        logic [2:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [1:0]  row;
        logic [3:0]  round;
        logic [31:0] expected;
    } vectorRow;

    logic               clk;
    logic               arstN;
    logic               wbCyc;
    logic               wbStb;
    logic               wbWe;
    aesUnitPkg::regAddr wbAdr;
    logic [31:0]        wbDatIn;
    logic [31:0]        wbDatOut;
    logic               wbAck;
    int                 errorCount;
    int                 timeoutCount;
    int                 checkCount;
    bit                 timedOut;
    int                 seed;
    vectorRow           vectors [$];

    `include "aesRefModel.svh"

    aesWordUnit u_dut (
        .clk      (clk),
        .arstN    (arstN),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatIn  (wbDatIn),
        .wbDatOut (wbDatOut),
        .wbAck    (wbAck)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic waitForAck();
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        while (!wbAck && cycles < ackTimeout) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!wbAck) begin
            $display("Timeout: no wbAck within %0d cycles at time %0t", ackTimeout, $time);
            timeoutCount++;
            timedOut = 1'b1;
        end
    endtask

    // Called just after a rising edge, returns just after a rising edge
    task automatic wbWrite(input aesUnitPkg::regAddr adr, input logic [31:0] data);
        if (timedOut) return;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b1;
        wbAdr = adr;
        wbDatIn = data;
        waitForAck();
        @(posedge clk);  // Request stays up through the acknowledge cycle
        #1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic wbRead(input aesUnitPkg::regAddr adr, output logic [31:0] data);
        data = 32'h0;
        if (timedOut) return;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b0;
        wbAdr = adr;
        waitForAck();
        data = wbDatOut;  // Registered with the acknowledge
        @(posedge clk);
        #1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
    endtask

    task automatic compareWord(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (timedOut) return;
        checkCount++;
        if (actual !== expected) begin
            $display("Fail at time %0t: %s expected %h, got %h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    function automatic logic [31:0] controlWord(input logic [2:0] op, input logic [1:0] row,
                                                input logic [3:0] round);
        return {20'h0, round, 2'b00, row, 1'b0, op};
    endfunction

    task automatic runOperation(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b,
                                input logic [1:0] row, input logic [3:0] round,
                                input logic [31:0] expected, input string name);
        logic [31:0] actual;
        wbWrite(aesUnitPkg::regSrcA, a);
        wbWrite(aesUnitPkg::regSrcB, b);
        wbWrite(aesUnitPkg::regCtrl, controlWord(op, row, round));
        wbRead(aesUnitPkg::regResult, actual);  // Stalls while the operation is in flight
        compareWord(name, expected, actual);
    endtask

    task automatic addVector(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b,
                             input logic [1:0] row, input logic [3:0] round,
                             input logic [31:0] expected);
        vectors.push_back('{op, a, b, row, round, expected});
    endtask

    task automatic buildVectorTable();
        addVector(aesUnitPkg::opXor, 32'h01234567, 32'hffff0000, 2'd0, 4'd0, 32'hfedc4567);
        addVector(aesUnitPkg::opXor, 32'h3243f6a8, 32'h2b7e1516, 2'd0, 4'd0, 32'h193de3be);
        addVector(aesUnitPkg::opPass, 32'hdeadbeef, 32'h12345678, 2'd0, 4'd0, 32'hdeadbeef);
        addVector(aesUnitPkg::opSubWord, 32'h00531001, 32'h0, 2'd0, 4'd0, 32'h63edca7c);
        addVector(aesUnitPkg::opSubWord, 32'h193de3be, 32'h0, 2'd0, 4'd0, 32'hd42711ae);
        addVector(aesUnitPkg::opMixColumn, 32'hdb135345, 32'h0, 2'd0, 4'd0, 32'h8e4da1bc);
        addVector(aesUnitPkg::opMixColumn, 32'hf20a225c, 32'h0, 2'd0, 4'd0, 32'h9fdc589d);
        addVector(aesUnitPkg::opMixColumn, 32'h01010101, 32'h0, 2'd0, 4'd0, 32'h01010101);
        addVector(aesUnitPkg::opMixColumn, 32'hd4bf5d30, 32'h0, 2'd0, 4'd0, 32'h046681e5);
        addVector(aesUnitPkg::opShiftRow, 32'h11223344, 32'h0, 2'd0, 4'd0, 32'h11223344);
        addVector(aesUnitPkg::opShiftRow, 32'h11223344, 32'h0, 2'd1, 4'd0, 32'h22334411);
        addVector(aesUnitPkg::opShiftRow, 32'h11223344, 32'h0, 2'd2, 4'd0, 32'h33441122);
        addVector(aesUnitPkg::opShiftRow, 32'h11223344, 32'h0, 2'd3, 4'd0, 32'h44112233);
        addVector(aesUnitPkg::opRcon, 32'h12345600, 32'h0, 2'd0, 4'd1, 32'h12345601);
        addVector(aesUnitPkg::opRcon, 32'h12345600, 32'h0, 2'd0, 4'd2, 32'h12345602);
        addVector(aesUnitPkg::opRcon, 32'h12345600, 32'h0, 2'd0, 4'd3, 32'h12345604);
        addVector(aesUnitPkg::opRcon, 32'h12345600, 32'h0, 2'd0, 4'd4, 32'h12345608);
        addVector(aesUnitPkg::opRcon, 32'h12345600, 32'h0, 2'd0, 4'd5, 32'h12345610);
        addVector(aesUnitPkg::opRcon, 32'h12345600, 32'h0, 2'd0, 4'd6, 32'h12345620);
        addVector(aesUnitPkg::opRcon, 32'h12345600, 32'h0, 2'd0, 4'd7, 32'h12345640);
        addVector(aesUnitPkg::opRcon, 32'h12345600, 32'h0, 2'd0, 4'd8, 32'h12345680);
        addVector(aesUnitPkg::opRcon, 32'h12345600, 32'h0, 2'd0, 4'd9, 32'h1234561b);
        addVector(aesUnitPkg::opRcon, 32'h12345600, 32'h0, 2'd0, 4'd10, 32'h12345636);
        addVector(aesUnitPkg::opRcon, 32'h12345600, 32'h0, 2'd1, 4'd1, 32'h12345600);
        addVector(aesUnitPkg::opRcon, 32'h12345600, 32'h0, 2'd0, 4'd0, 32'h12345600);
        addVector(aesUnitPkg::opRcon, 32'h12345600, 32'h0, 2'd0, 4'd11, 32'h12345600);
        addVector(3'd6, 32'hffffffff, 32'h0f0f0f0f, 2'd0, 4'd0, 32'h00000000);
        addVector(3'd7, 32'hffffffff, 32'hf0f0f0f0, 2'd0, 4'd0, 32'h00000000);
    endtask

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] readValue;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = aesUnitPkg::regSrcA;
        wbDatIn = 32'h0;
        errorCount = 0;
        timeoutCount = 0;
        checkCount = 0;
        timedOut = 1'b0;
        seed = 32'ha734d72e;
        arstN = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arstN = 1'b1;

        wbRead(aesUnitPkg::regResult, readValue);
        compareWord("result after reset", 32'h0, readValue);

        buildVectorTable();
        for (int i = 0; i < vectors.size() && !timedOut; i++) begin
            runOperation(vectors[i].op, vectors[i].a, vectors[i].b, vectors[i].row,
                         vectors[i].round, vectors[i].expected,
                         $sformatf("result of vector %0d", i));
        end

        // Register readback after a shift row
        a = 32'ha1b2c3d4;
        b = 32'h5566778a;
        runOperation(aesUnitPkg::opShiftRow, a, b, 2'd3, 4'd10, 32'hd4a1b2c3,
                     "result readback op");
        wbRead(aesUnitPkg::regSrcA, readValue);
        compareWord("regSrcA", a, readValue);
        wbRead(aesUnitPkg::regSrcB, readValue);
        compareWord("regSrcB", b, readValue);
        wbRead(aesUnitPkg::regCtrl, readValue);
        compareWord("regCtrl", 32'h00000a32, readValue);

        // Back-to-back issues leave the second result
        a = 32'h11223344;
        b = 32'h01010101;
        wbWrite(aesUnitPkg::regSrcA, a);
        wbWrite(aesUnitPkg::regSrcB, b);
        wbWrite(aesUnitPkg::regCtrl, controlWord(aesUnitPkg::opPass, 2'd0, 4'd0));
        wbWrite(aesUnitPkg::regCtrl, controlWord(aesUnitPkg::opXor, 2'd0, 4'd0));
        wbRead(aesUnitPkg::regResult, readValue);
        compareWord("result after two issues", 32'h10233245, readValue);

        for (int n = 0; n < randomChecks && !timedOut; n++) begin
            r = $random(seed);
            a = $random(seed);
            b = $random(seed);
            runOperation(r[2:0], a, b, r[5:4], r[11:8],
                         expectedResult(r[2:0], a, b, r[5:4], r[11:8]),
                         $sformatf("result of random op %0d", n));
        end

        $display("Checks %0d, value errors %0d, timeouts %0d", checkCount, errorCount,
                 timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+testbench
logic/aesMathPkg.sv
logic/aesUnitPkg.sv
logic/wbCmdPort.sv
logic/byteLane.sv
logic/wordCombiner.sv
logic/aesWordUnit.sv
testbench/tbAesWordUnit.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tbAesWordUnit -Mdir build -o simAesWordUnit -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./build/simAesWordUnit > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported errors"
    exit 1
fi

echo "Simulation clean"
exit 0
